// File: design/id_pkg.sv
// decode stage shared definitions
`default_nettype none

package id_pkg;

  localparam int XLEN        = 32;
  localparam int INST_WD     = 32;
  localparam int REG_ADDR_WD = 5;
  localparam int REG_NUM     = 32;
  localparam int ALU_OP_WD   = 4;
  localparam int MEM_OP_WD   = 3;
  localparam int F3_WD       = 3;

  // major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  localparam logic [F3_WD-1:0] F3_BEQ  = 3'b000;
  localparam logic [F3_WD-1:0] F3_BNE  = 3'b001;
  localparam logic [F3_WD-1:0] F3_BLT  = 3'b100;
  localparam logic [F3_WD-1:0] F3_BGE  = 3'b101;
  localparam logic [F3_WD-1:0] F3_BLTU = 3'b110;
  localparam logic [F3_WD-1:0] F3_BGEU = 3'b111;
  localparam logic [F3_WD-1:0] F3_SRX  = 3'b101; // srli / srai share this

  localparam logic [ALU_OP_WD-1:0] ALU_ADD = 4'b0000;

  // fetch receiver states
  localparam logic RX_IDLE = 1'b0;
  localparam logic RX_ACK  = 1'b1;

  // issue sender states
  localparam logic [1:0] TX_IDLE = 2'd0;
  localparam logic [1:0] TX_REQ  = 2'd1;
  localparam logic [1:0] TX_WAIT = 2'd2;

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic [19:0] imm20;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
  } inst_u;

endpackage

`default_nettype wire

// File: design/id_fetch_rx.sv
// fetch side receiver
`timescale 1ns/1ps
`default_nettype none

module id_fetch_rx import id_pkg::*; (
  input  wire                i_clk,
  input  wire                i_rst_n,
  input  wire                i_fs_req,
  input  wire [INST_WD-1:0]  i_fs_inst,
  input  wire [XLEN-1:0]     i_fs_pc,
  output logic               o_fs_ack,
  input  wire                i_take,
  output logic               o_slot_full,
  output logic [INST_WD-1:0] o_inst,
  output logic [XLEN-1:0]    o_pc
);

  logic rx_state;
  logic accept;

  // only a fresh request into an empty slot is taken
  assign accept   = (rx_state == RX_IDLE) && i_fs_req && !o_slot_full;
  assign o_fs_ack = (rx_state == RX_ACK);

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      rx_state    <= RX_IDLE;
      o_slot_full <= 1'b0;
    end else begin
      if (rx_state == RX_IDLE) begin
        if (accept) begin
          rx_state <= RX_ACK;
        end
      end else if (!i_fs_req) begin
        rx_state <= RX_IDLE; // fetch dropped req, ack follows
      end

      if (accept) begin
        o_slot_full <= 1'b1;
      end else if (i_take) begin
        o_slot_full <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_inst <= i_fs_inst;
      o_pc   <= i_fs_pc;
    end
  end

endmodule

`default_nettype wire

// File: design/id_decoder.sv
// instruction decoder
`timescale 1ns/1ps
`default_nettype none

module id_decoder import id_pkg::*; (
  input  wire  [INST_WD-1:0]     i_inst,
  output logic [REG_ADDR_WD-1:0] o_rs1,
  output logic [REG_ADDR_WD-1:0] o_rs2,
  output logic [REG_ADDR_WD-1:0] o_rd,
  output logic [XLEN-1:0]        o_imm,
  output logic [ALU_OP_WD-1:0]   o_alu_op,
  output logic                   o_gpr_wen,
  output logic                   o_mem_ren,
  output logic                   o_mem_wen,
  output logic [MEM_OP_WD-1:0]   o_mem_op,
  output logic                   o_bren,
  output logic [F3_WD-1:0]       o_brfunc,
  output logic                   o_jal,
  output logic                   o_jalr,
  output logic                   o_invalid
);

  inst_u           ins;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm_u;

  assign ins = i_inst;

  assign imm_i = {{20{ins.i.imm12[11]}}, ins.i.imm12};
  assign imm_s = {{20{ins.s.imm_hi[6]}}, ins.s.imm_hi, ins.s.imm_lo};
  assign imm_b = {{19{ins.s.imm_hi[6]}}, ins.s.imm_hi[6], ins.s.imm_lo[0],
                  ins.s.imm_hi[5:0], ins.s.imm_lo[4:1], 1'b0};
  // j-type bits are scattered across imm20
  assign imm_j = {{11{ins.u.imm20[19]}}, ins.u.imm20[19], ins.u.imm20[7:0],
                  ins.u.imm20[8], ins.u.imm20[18:9], 1'b0};
  assign imm_u = {ins.u.imm20, 12'b0};

  always_comb begin
    o_rs1     = ins.i.rs1;
    o_rs2     = '0;
    o_rd      = '0;
    o_imm     = '0;
    o_alu_op  = ALU_ADD;
    o_gpr_wen = 1'b0;
    o_mem_ren = 1'b0;
    o_mem_wen = 1'b0;
    o_mem_op  = '0;
    o_bren    = 1'b0;
    o_brfunc  = '0;
    o_jal     = 1'b0;
    o_jalr    = 1'b0;
    o_invalid = 1'b0;
    case (ins.r.opcode)
      OPC_OP: begin
        o_rs2     = ins.r.rs2;
        o_rd      = ins.r.rd;
        o_alu_op  = {ins.r.funct7[5], ins.r.funct3};
        o_gpr_wen = 1'b1;
      end
      OPC_OP_IMM: begin
        o_rd      = ins.i.rd;
        o_imm     = imm_i;
        o_alu_op  = (ins.i.funct3 == F3_SRX) ? {ins.i.imm12[10], ins.i.funct3}
                                             : {1'b0, ins.i.funct3};
        o_gpr_wen = 1'b1;
      end
      OPC_LOAD: begin
        o_rd      = ins.i.rd;
        o_imm     = imm_i;
        o_gpr_wen = 1'b1;
        o_mem_ren = 1'b1;
        o_mem_op  = ins.i.funct3;
      end
      OPC_STORE: begin
        o_rs2     = ins.s.rs2;
        o_imm     = imm_s;
        o_mem_wen = 1'b1;
        o_mem_op  = ins.s.funct3;
      end
      OPC_BRANCH: begin
        o_rs2    = ins.s.rs2;
        o_imm    = imm_b;
        o_bren   = 1'b1;
        o_brfunc = ins.s.funct3;
      end
      OPC_JAL: begin
        o_rs1     = '0;
        o_rd      = ins.u.rd;
        o_imm     = imm_j;
        o_gpr_wen = 1'b1;
        o_jal     = 1'b1;
      end
      OPC_JALR: begin
        o_rd      = ins.i.rd;
        o_imm     = imm_i;
        o_gpr_wen = 1'b1;
        o_jalr    = 1'b1;
      end
      OPC_LUI: begin
        o_rs1     = '0;
        o_rd      = ins.u.rd;
        o_imm     = imm_u;
        o_gpr_wen = 1'b1;
      end
      default: begin
        o_rs1     = '0; // unknown opcode, nothing enabled
        o_invalid = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: design/id_regfile.sv
// general purpose register file
`timescale 1ns/1ps
`default_nettype none

module id_regfile import id_pkg::*; (
  input  wire                   i_clk,
  input  wire [REG_ADDR_WD-1:0] i_raddr1,
  output logic [XLEN-1:0]       o_rdata1,
  input  wire [REG_ADDR_WD-1:0] i_raddr2,
  output logic [XLEN-1:0]       o_rdata2,
  input  wire                   i_wen,
  input  wire [REG_ADDR_WD-1:0] i_waddr,
  input  wire [XLEN-1:0]        i_wdata
);

  logic [XLEN-1:0] regs [1:REG_NUM-1]; // x0 not stored

  function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_WD-1:0] addr);
    logic [XLEN-1:0] data;
    if (addr == '0) begin
      data = '0;
    end else if (i_wen && (i_waddr == addr)) begin
      data = i_wdata; // same-cycle write-back
    end else begin
      data = regs[addr];
    end
    return data;
  endfunction

  always_comb begin
    o_rdata1 = read_port(i_raddr1);
    o_rdata2 = read_port(i_raddr2);
  end

  always_ff @(posedge i_clk) begin
    if (i_wen && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

endmodule

`default_nettype wire

// File: design/id_branch_unit.sv
// branch and jump resolution
`timescale 1ns/1ps
`default_nettype none

module id_branch_unit import id_pkg::*; (
  input  wire  [XLEN-1:0]  i_pc,
  input  wire  [XLEN-1:0]  i_rs1_data,
  input  wire  [XLEN-1:0]  i_rs2_data,
  input  wire  [XLEN-1:0]  i_imm,
  input  wire              i_bren,
  input  wire  [F3_WD-1:0] i_brfunc,
  input  wire              i_jal,
  input  wire              i_jalr,
  output logic             o_taken,
  output logic [XLEN-1:0]  o_target
);

  logic            cond;
  logic [XLEN-1:0] pc_rel;
  logic [XLEN-1:0] reg_rel;

  always_comb begin
    case (i_brfunc)
      F3_BEQ:  cond = (i_rs1_data == i_rs2_data);
      F3_BNE:  cond = (i_rs1_data != i_rs2_data);
      F3_BLT:  cond = ($signed(i_rs1_data) < $signed(i_rs2_data));
      F3_BGE:  cond = ($signed(i_rs1_data) >= $signed(i_rs2_data));
      F3_BLTU: cond = (i_rs1_data < i_rs2_data);
      F3_BGEU: cond = (i_rs1_data >= i_rs2_data);
      default: cond = 1'b0;
    endcase
  end

  assign pc_rel  = i_pc + i_imm;
  assign reg_rel = i_rs1_data + i_imm;
  assign o_taken = i_jal || i_jalr || (i_bren && cond);

  always_comb begin
    if (i_jalr) begin
      o_target = {reg_rel[XLEN-1:1], 1'b0}; // lsb cleared
    end else if (o_taken) begin
      o_target = pc_rel;
    end else begin
      o_target = i_pc + 32'd4; // fall through
    end
  end

endmodule

`default_nettype wire

// File: design/id_issue_tx.sv
// issue register and execute side sender
`timescale 1ns/1ps
`default_nettype none

module id_issue_tx import id_pkg::*; (
  input  wire                    i_clk,
  input  wire                    i_rst_n,
  input  wire                    i_slot_full,
  output logic                   o_take,
  input  wire  [XLEN-1:0]        i_pc,
  input  wire  [XLEN-1:0]        i_rs1_data,
  input  wire  [XLEN-1:0]        i_rs2_data,
  input  wire  [XLEN-1:0]        i_imm,
  input  wire  [REG_ADDR_WD-1:0] i_rd,
  input  wire  [ALU_OP_WD-1:0]   i_alu_op,
  input  wire                    i_gpr_wen,
  input  wire                    i_mem_ren,
  input  wire                    i_mem_wen,
  input  wire  [MEM_OP_WD-1:0]   i_mem_op,
  input  wire                    i_invalid,
  input  wire                    i_br_taken,
  input  wire  [XLEN-1:0]        i_br_target,
  output logic                   o_es_req,
  input  wire                    i_es_ack,
  output logic [XLEN-1:0]        o_es_pc,
  output logic [XLEN-1:0]        o_es_rs1_data,
  output logic [XLEN-1:0]        o_es_rs2_data,
  output logic [XLEN-1:0]        o_es_imm,
  output logic [REG_ADDR_WD-1:0] o_es_rd,
  output logic [ALU_OP_WD-1:0]   o_es_alu_op,
  output logic                   o_es_gpr_wen,
  output logic                   o_es_mem_ren,
  output logic                   o_es_mem_wen,
  output logic [MEM_OP_WD-1:0]   o_es_mem_op,
  output logic                   o_es_invalid,
  output logic                   o_es_br_taken,
  output logic [XLEN-1:0]        o_es_br_target
);

  logic [1:0] tx_state;
  logic       squash; // next capture is wrong-path

  assign o_take   = i_slot_full && (tx_state == TX_IDLE);
  assign o_es_req = (tx_state == TX_REQ);

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      tx_state <= TX_IDLE;
      squash   <= 1'b0;
    end else begin
      case (tx_state)
        TX_IDLE: begin
          if (o_take) begin
            if (squash) begin
              squash <= 1'b0; // acked to fetch, never issued
            end else begin
              squash   <= i_br_taken;
              tx_state <= TX_REQ;
            end
          end
        end
        TX_REQ:  if (i_es_ack) tx_state <= TX_WAIT;
        TX_WAIT: if (!i_es_ack) tx_state <= TX_IDLE;
        default: tx_state <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_take && !squash) begin
      o_es_pc        <= i_pc;
      o_es_rs1_data  <= i_rs1_data;
      o_es_rs2_data  <= i_rs2_data;
      o_es_imm       <= i_imm;
      o_es_rd        <= i_rd;
      o_es_alu_op    <= i_alu_op;
      o_es_gpr_wen   <= i_gpr_wen;
      o_es_mem_ren   <= i_mem_ren;
      o_es_mem_wen   <= i_mem_wen;
      o_es_mem_op    <= i_mem_op;
      o_es_invalid   <= i_invalid;
      o_es_br_taken  <= i_br_taken;
      o_es_br_target <= i_br_target;
    end
  end

endmodule

`default_nettype wire

// File: design/id_stage.sv
// rv32i instruction decode stage
`timescale 1ns/1ps
`default_nettype none

module id_stage import id_pkg::*; (
  input  wire                    i_clk,
  input  wire                    i_rst_n,
  input  wire                    i_fs_req,
  input  wire  [INST_WD-1:0]     i_fs_inst,
  input  wire  [XLEN-1:0]        i_fs_pc,
  output logic                   o_fs_ack,
  input  wire                    i_wb_en,
  input  wire  [REG_ADDR_WD-1:0] i_wb_addr,
  input  wire  [XLEN-1:0]        i_wb_data,
  output logic                   o_es_req,
  input  wire                    i_es_ack,
  output logic [XLEN-1:0]        o_es_pc,
  output logic [XLEN-1:0]        o_es_rs1_data,
  output logic [XLEN-1:0]        o_es_rs2_data,
  output logic [XLEN-1:0]        o_es_imm,
  output logic [REG_ADDR_WD-1:0] o_es_rd,
  output logic [ALU_OP_WD-1:0]   o_es_alu_op,
  output logic                   o_es_gpr_wen,
  output logic                   o_es_mem_ren,
  output logic                   o_es_mem_wen,
  output logic [MEM_OP_WD-1:0]   o_es_mem_op,
  output logic                   o_es_invalid,
  output logic                   o_es_br_taken,
  output logic [XLEN-1:0]        o_es_br_target
);

  logic                   slot_full;
  logic                   take;
  logic [INST_WD-1:0]     inst;
  logic [XLEN-1:0]        pc;
  logic [REG_ADDR_WD-1:0] rs1;
  logic [REG_ADDR_WD-1:0] rs2;
  logic [REG_ADDR_WD-1:0] rd;
  logic [XLEN-1:0]        rs1_data;
  logic [XLEN-1:0]        rs2_data;
  logic [XLEN-1:0]        imm;
  logic [ALU_OP_WD-1:0]   alu_op;
  logic                   gpr_wen;
  logic                   mem_ren;
  logic                   mem_wen;
  logic [MEM_OP_WD-1:0]   mem_op;
  logic                   bren;
  logic [F3_WD-1:0]       brfunc;
  logic                   jal;
  logic                   jalr;
  logic                   invalid;
  logic                   br_taken;
  logic [XLEN-1:0]        br_target;

  id_fetch_rx u_fetch_rx (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_fs_req(i_fs_req), .i_fs_inst(i_fs_inst), .i_fs_pc(i_fs_pc), .o_fs_ack(o_fs_ack),
    .i_take(take), .o_slot_full(slot_full), .o_inst(inst), .o_pc(pc)
  );

  id_decoder u_decoder (
    .i_inst(inst), .o_rs1(rs1), .o_rs2(rs2), .o_rd(rd), .o_imm(imm), .o_alu_op(alu_op),
    .o_gpr_wen(gpr_wen), .o_mem_ren(mem_ren), .o_mem_wen(mem_wen), .o_mem_op(mem_op),
    .o_bren(bren), .o_brfunc(brfunc), .o_jal(jal), .o_jalr(jalr), .o_invalid(invalid)
  );

  // write-back is the only forwarding source
  id_regfile u_regfile (
    .i_clk(i_clk), .i_raddr1(rs1), .o_rdata1(rs1_data), .i_raddr2(rs2), .o_rdata2(rs2_data),
    .i_wen(i_wb_en), .i_waddr(i_wb_addr), .i_wdata(i_wb_data)
  );

  id_branch_unit u_branch_unit (
    .i_pc(pc), .i_rs1_data(rs1_data), .i_rs2_data(rs2_data), .i_imm(imm),
    .i_bren(bren), .i_brfunc(brfunc), .i_jal(jal), .i_jalr(jalr),
    .o_taken(br_taken), .o_target(br_target)
  );

  id_issue_tx u_issue_tx (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_slot_full(slot_full), .o_take(take),
    .i_pc(pc), .i_rs1_data(rs1_data), .i_rs2_data(rs2_data), .i_imm(imm), .i_rd(rd),
    .i_alu_op(alu_op), .i_gpr_wen(gpr_wen), .i_mem_ren(mem_ren), .i_mem_wen(mem_wen),
    .i_mem_op(mem_op), .i_invalid(invalid), .i_br_taken(br_taken), .i_br_target(br_target),
    .o_es_req(o_es_req), .i_es_ack(i_es_ack),
    .o_es_pc(o_es_pc), .o_es_rs1_data(o_es_rs1_data), .o_es_rs2_data(o_es_rs2_data),
    .o_es_imm(o_es_imm), .o_es_rd(o_es_rd), .o_es_alu_op(o_es_alu_op),
    .o_es_gpr_wen(o_es_gpr_wen), .o_es_mem_ren(o_es_mem_ren), .o_es_mem_wen(o_es_mem_wen),
    .o_es_mem_op(o_es_mem_op), .o_es_invalid(o_es_invalid),
    .o_es_br_taken(o_es_br_taken), .o_es_br_target(o_es_br_target)
  );

endmodule

`default_nettype wire

// File: test/id_stage_sva.sv
// decode stage handshake checks
`timescale 1ns/1ps
`default_nettype none

module id_stage_sva import id_pkg::*; (
  input wire                   i_clk,
  input wire                   i_rst_n,
  input wire                   i_fs_req,
  input wire                   o_fs_ack,
  input wire                   o_es_req,
  input wire                   i_es_ack,
  input wire [XLEN-1:0]        o_es_pc,
  input wire [XLEN-1:0]        o_es_rs1_data,
  input wire [XLEN-1:0]        o_es_rs2_data,
  input wire [XLEN-1:0]        o_es_imm,
  input wire [REG_ADDR_WD-1:0] o_es_rd,
  input wire [ALU_OP_WD-1:0]   o_es_alu_op,
  input wire                   o_es_gpr_wen,
  input wire                   o_es_mem_ren,
  input wire                   o_es_mem_wen,
  input wire [MEM_OP_WD-1:0]   o_es_mem_op,
  input wire                   o_es_invalid,
  input wire                   o_es_br_taken,
  input wire [XLEN-1:0]        o_es_br_target
);

  int n_fail = 0; // failed assertions so far

  req_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_es_req && !i_es_ack |=> o_es_req && $stable({o_es_pc, o_es_rs1_data, o_es_rs2_data,
      o_es_imm, o_es_rd, o_es_alu_op, o_es_gpr_wen, o_es_mem_ren, o_es_mem_wen,
      o_es_mem_op, o_es_invalid, o_es_br_taken, o_es_br_target}))
    else begin
      $error("o_es_req or the bundle changed before i_es_ack");
      n_fail++;
    end

  // ack only follows a live request
  ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !i_fs_req |=> !o_fs_ack)
    else begin
      $error("o_fs_ack high one cycle after i_fs_req was low");
      n_fail++;
    end

  quiet_in_reset: assert property (@(posedge i_clk) !i_rst_n |=> !o_es_req && !o_fs_ack)
    else begin
      $error("handshake output high after a reset cycle");
      n_fail++;
    end

endmodule

bind id_stage id_stage_sva sva_i (
  .i_clk(i_clk), .i_rst_n(i_rst_n), .i_fs_req(i_fs_req), .o_fs_ack(o_fs_ack),
  .o_es_req(o_es_req), .i_es_ack(i_es_ack), .o_es_pc(o_es_pc),
  .o_es_rs1_data(o_es_rs1_data), .o_es_rs2_data(o_es_rs2_data), .o_es_imm(o_es_imm),
  .o_es_rd(o_es_rd), .o_es_alu_op(o_es_alu_op), .o_es_gpr_wen(o_es_gpr_wen),
  .o_es_mem_ren(o_es_mem_ren), .o_es_mem_wen(o_es_mem_wen), .o_es_mem_op(o_es_mem_op),
  .o_es_invalid(o_es_invalid), .o_es_br_taken(o_es_br_taken),
  .o_es_br_target(o_es_br_target)
);

`default_nettype wire

// File: test/id_stage_tb.sv
// decode stage testbench
`timescale 1ns/1ps
`default_nettype none

module id_stage_tb import id_pkg::*; ();

  localparam int N          = 18;
  localparam int TIMEOUT_NS = (N * 40 + 10) * 4;

  typedef struct packed {
    logic [XLEN-1:0]        pc;
    logic [XLEN-1:0]        rs1_data;
    logic [XLEN-1:0]        rs2_data;
    logic [XLEN-1:0]        imm;
    logic [REG_ADDR_WD-1:0] rd;
    logic [ALU_OP_WD-1:0]   alu_op;
    logic                   gpr_wen;
    logic                   mem_ren;
    logic                   mem_wen;
    logic [MEM_OP_WD-1:0]   mem_op;
    logic                   invalid;
    logic                   br_taken;
    logic [XLEN-1:0]        br_target;
  } bundle_t;

  logic                   i_clk;
  logic                   i_rst_n;
  logic                   i_fs_req;
  logic [INST_WD-1:0]     i_fs_inst;
  logic [XLEN-1:0]        i_fs_pc;
  logic                   o_fs_ack;
  logic                   i_wb_en;
  logic [REG_ADDR_WD-1:0] i_wb_addr;
  logic [XLEN-1:0]        i_wb_data;
  logic                   o_es_req;
  logic                   i_es_ack;
  bundle_t                dut_out;

  string                  tab_name  [N];
  logic [INST_WD-1:0]     tab_inst  [N];
  logic                   tab_wen   [N];
  logic [REG_ADDR_WD-1:0] tab_waddr [N];
  logic [XLEN-1:0]        tab_wdata [N];
  logic                   tab_squash [N];
  logic [XLEN-1:0]        shadow [REG_NUM];
  bundle_t                exp_q [$];
  int                     idx_q [$];
  logic [31:0]            rnd = 32'd40;
  int                     errors = 0;
  int                     n_issued = 0;
  int                     n_expect = 0;

  id_stage id_stage_i (
    .i_clk(i_clk), .i_rst_n(i_rst_n),
    .i_fs_req(i_fs_req), .i_fs_inst(i_fs_inst), .i_fs_pc(i_fs_pc), .o_fs_ack(o_fs_ack),
    .i_wb_en(i_wb_en), .i_wb_addr(i_wb_addr), .i_wb_data(i_wb_data),
    .o_es_req(o_es_req), .i_es_ack(i_es_ack),
    .o_es_pc(dut_out.pc), .o_es_rs1_data(dut_out.rs1_data), .o_es_rs2_data(dut_out.rs2_data),
    .o_es_imm(dut_out.imm), .o_es_rd(dut_out.rd), .o_es_alu_op(dut_out.alu_op),
    .o_es_gpr_wen(dut_out.gpr_wen), .o_es_mem_ren(dut_out.mem_ren),
    .o_es_mem_wen(dut_out.mem_wen), .o_es_mem_op(dut_out.mem_op),
    .o_es_invalid(dut_out.invalid), .o_es_br_taken(dut_out.br_taken),
    .o_es_br_target(dut_out.br_target)
  );

  always #2 i_clk = ~i_clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic add_entry(input int k, input string name, input logic [31:0] inst,
                           input logic wen, input logic [4:0] waddr, input logic [31:0] wdata);
    tab_name[k]  = name;
    tab_inst[k]  = inst;
    tab_wen[k]   = wen;
    tab_waddr[k] = waddr;
    tab_wdata[k] = wdata;
  endtask

  // expected bundle from the rv32i field layout
  function automatic bundle_t predict(input logic [31:0] w, input logic [31:0] pc);
    bundle_t     b;
    logic [4:0]  r1;
    logic [4:0]  r2;
    logic [31:0] a;
    logic [31:0] c;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic        take;
    b     = '0;
    r1    = w[19:15];
    r2    = 5'd0;
    take  = 1'b0;
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    b.pc  = pc;
    case (w[6:0])
      OPC_OP: begin
        r2        = w[24:20];
        b.rd      = w[11:7];
        b.alu_op  = {w[30], w[14:12]};
        b.gpr_wen = 1'b1;
      end
      OPC_OP_IMM: begin
        b.rd      = w[11:7];
        b.imm     = imm_i;
        b.gpr_wen = 1'b1;
        b.alu_op  = (w[14:12] == 3'd5) ? {w[30], w[14:12]} : {1'b0, w[14:12]};
      end
      OPC_LOAD: begin
        b.rd      = w[11:7];
        b.imm     = imm_i;
        b.gpr_wen = 1'b1;
        b.mem_ren = 1'b1;
        b.mem_op  = w[14:12];
      end
      OPC_STORE: begin
        r2        = w[24:20];
        b.imm     = imm_s;
        b.mem_wen = 1'b1;
        b.mem_op  = w[14:12];
      end
      OPC_BRANCH: begin
        r2    = w[24:20];
        b.imm = imm_b;
      end
      OPC_JAL: begin
        r1        = 5'd0;
        b.rd      = w[11:7];
        b.imm     = imm_j;
        b.gpr_wen = 1'b1;
        take      = 1'b1;
      end
      OPC_JALR: begin
        b.rd      = w[11:7];
        b.imm     = imm_i;
        b.gpr_wen = 1'b1;
        take      = 1'b1;
      end
      OPC_LUI: begin
        r1        = 5'd0;
        b.rd      = w[11:7];
        b.imm     = {w[31:12], 12'b0};
        b.gpr_wen = 1'b1;
      end
      default: begin
        r1        = 5'd0;
        b.invalid = 1'b1;
      end
    endcase
    a = (r1 == 5'd0) ? 32'd0 : shadow[r1];
    c = (r2 == 5'd0) ? 32'd0 : shadow[r2];
    b.rs1_data = a;
    b.rs2_data = c;
    if (w[6:0] == OPC_BRANCH) begin
      case (w[14:12])
        3'd0: take = (a == c);
        3'd1: take = (a != c);
        3'd4: take = ($signed(a) < $signed(c));
        3'd5: take = ($signed(a) >= $signed(c));
        3'd6: take = (a < c);
        3'd7: take = (a >= c);
        default: take = 1'b0;
      endcase
    end
    b.br_taken = take;
    if (!take) b.br_target = pc + 32'd4;
    else if (w[6:0] == OPC_JALR) b.br_target = (a + b.imm) & ~32'd1;
    else b.br_target = pc + b.imm;
    return b;
  endfunction

  task automatic build_expected();
    logic    squash;
    bundle_t b;
    squash = 1'b0;
    for (int k = 0; k < N; k++) begin
      if (tab_wen[k] && tab_waddr[k] != 5'd0) shadow[tab_waddr[k]] = tab_wdata[k];
      b = predict(tab_inst[k], 32'h100 + 32'(k * 4));
      tab_squash[k] = squash;
      if (squash) begin
        squash = 1'b0; // wrong-path slot
      end else begin
        exp_q.push_back(b);
        idx_q.push_back(k);
        n_expect++;
        squash = b.br_taken;
      end
    end
  endtask

  initial begin : fetch_driver
    i_clk     = 1'b0;
    i_rst_n   = 1'b0;
    i_fs_req  = 1'b0;
    i_fs_inst = '0;
    i_fs_pc   = '0;
    i_wb_en   = 1'b0;
    i_wb_addr = '0;
    i_wb_data = '0;
    for (int r = 0; r < REG_NUM; r++) shadow[r] = '0;
    add_entry(0,  "lui",        32'h123452B7, 1'b1, 5'd1, 32'd5);
    add_entry(1,  "addi",       32'hFFD08193, 1'b1, 5'd2, 32'hFFFFFFF0);
    add_entry(2,  "add_x0",     32'h00008233, 1'b1, 5'd0, 32'h0000DEAD);
    add_entry(3,  "sub_fwd",    32'h402303B3, 1'b1, 5'd6, 32'd7);
    add_entry(4,  "srai",       32'h40415413, 1'b0, 5'd0, 32'd0);
    add_entry(5,  "lw",         32'h0080A483, 1'b0, 5'd0, 32'd0);
    add_entry(6,  "sw",         32'hFE20AE23, 1'b0, 5'd0, 32'd0);
    add_entry(7,  "beq_nt",     32'h00208863, 1'b0, 5'd0, 32'd0);
    add_entry(8,  "blt_t",      32'h00114463, 1'b0, 5'd0, 32'd0);
    add_entry(9,  "shadow1",    32'h00100093, 1'b0, 5'd0, 32'd0);
    add_entry(10, "bltu_nt",    32'h00116463, 1'b0, 5'd0, 32'd0);
    add_entry(11, "jal",        32'h010000EF, 1'b0, 5'd0, 32'd0);
    add_entry(12, "shadow2",    32'h00000013, 1'b0, 5'd0, 32'd0);
    add_entry(13, "jalr",       32'h00208567, 1'b0, 5'd0, 32'd0);
    add_entry(14, "shadow3",    32'h00000013, 1'b0, 5'd0, 32'd0);
    add_entry(15, "invalid",    32'hFFFFFFFF, 1'b0, 5'd0, 32'd0);
    add_entry(16, "bne_back",   32'hFE609CE3, 1'b0, 5'd0, 32'd0);
    add_entry(17, "shadow4",    32'h00000013, 1'b0, 5'd0, 32'd0);
    build_expected();
    repeat (10) @(posedge i_clk);
    #1;
    assert (!o_fs_ack && !o_es_req) else begin
      $display("error %0t: handshake outputs high during reset", $time);
      errors++;
    end
    i_rst_n = 1'b1;
    for (int k = 0; k < N; k++) begin
      while (o_fs_ack) begin
        @(posedge i_clk);
        #1;
      end
      i_fs_req  = 1'b1;
      i_fs_inst = tab_inst[k];
      i_fs_pc   = 32'h100 + 32'(k * 4);
      do begin
        @(posedge i_clk);
        #1;
      end while (!o_fs_ack);
      // write-back lands while this entry sits in the slot
      i_wb_en   = tab_wen[k];
      i_wb_addr = tab_waddr[k];
      i_wb_data = tab_wdata[k];
      i_fs_req  = 1'b0;
      if (tab_squash[k]) $display("test %0d %s: acked, not issued", k, tab_name[k]);
    end
    while (exp_q.size() != 0 || o_es_req || i_es_ack) begin
      @(posedge i_clk);
      #1;
    end
    repeat (4) @(posedge i_clk);
    assert (n_issued == n_expect) else begin
      $display("error %0t: %0d bundles issued, %0d expected", $time, n_issued, n_expect);
      errors++;
    end
    errors += id_stage_i.sva_i.n_fail;
    $display("entries %0d issued %0d errors %0d", N, n_issued, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin : exec_responder
    bundle_t    exp;
    int         idx;
    logic [1:0] delay;
    logic       ok;
    i_es_ack = 1'b0;
    forever begin
      @(posedge i_clk);
      #1;
      if (i_rst_n && o_es_req && !i_es_ack) begin
        n_issued++;
        if (exp_q.size() == 0) begin
          $display("error %0t: bundle issued with nothing expected", $time);
          errors++;
        end else begin
          exp = exp_q.pop_front();
          idx = idx_q.pop_front();
          ok  = (dut_out === exp);
          assert (ok) else begin
            $display("error %0t: %s got %h expected %h", $time, tab_name[idx], dut_out, exp);
            errors++;
          end
          $display("test %0d %s: %s", idx, tab_name[idx], ok ? "ok" : "mismatch");
        end
        rnd   = xorshift(rnd);
        delay = rnd[1:0]; // 0 to 3 cycles of back-pressure
        repeat (delay) begin
          @(posedge i_clk);
          #1;
        end
        i_es_ack = 1'b1;
        do begin
          @(posedge i_clk);
          #1;
        end while (o_es_req);
        i_es_ack = 1'b0;
      end
    end
  end

  initial begin : watchdog
    #TIMEOUT_NS;
    $display("timeout: the run did not finish in the allowed time");
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
design/id_pkg.sv
design/id_fetch_rx.sv
design/id_decoder.sv
design/id_regfile.sv
design/id_branch_unit.sv
design/id_issue_tx.sv
design/id_stage.sv
test/id_stage_sva.sv
test/id_stage_tb.sv

// File: Makefile
TOP = id_stage_tb

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean
